//--- bench/tb_pc_config.sv
`default_nettype none

`include "pc_cfg.svh"

module tb_pc_config;

  import pc_pkg::*;

  localparam int NUM_WORDS     = 600;
  localparam int TRAFFIC_LIMIT = 20000;
  localparam int DRAIN_LIMIT   = 500;
  // idle cycles that prove the pipe is empty
  localparam int QUIET_CYCLES  = 4;

  logic                         clk;
  logic                         reset;
  logic                         stall;
  logic                         pc_in_v;
  pc_word_t                     pc_in_d;
  logic                         pc_in_a;
  conf_data_t [`NUM_REGS-1:0]   conf_regs;
  logic [`NUM_CHANS-1:0]        chan_v;
  conf_wide_t [`NUM_CHANS-1:0]  chan_d;
  logic [`NUM_CHANS-1:0]        chan_a;
  logic                         bd_v;
  leaf_code_t                   bd_leaf;
  bd_payload_t                  bd_payload;
  logic                         bd_a;

  pc_config_top u_pc_config_top (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .pc_in_v    (pc_in_v),
    .pc_in_d    (pc_in_d),
    .pc_in_a    (pc_in_a),
    .conf_regs  (conf_regs),
    .chan_v     (chan_v),
    .chan_d     (chan_d),
    .chan_a     (chan_a),
    .bd_v       (bd_v),
    .bd_leaf    (bd_leaf),
    .bd_payload (bd_payload),
    .bd_a       (bd_a)
  );

  always #4 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // reference model state

  logic [31:0]                    rng;
  conf_data_t                     model_regs [`NUM_REGS];
  // expected joined words, one queue per channel
  conf_wide_t                     chan_exp [`NUM_CHANS][$];
  conf_wide_t                     gather [`NUM_CHANS];
  int                             gather_cnt [`NUM_CHANS];
  // expected {leaf, payload} in acceptance order
  logic [`LEAF_W+`BD_DATA_W-1:0]  bd_exp [$];
  int                             errors;
  int                             checks;
  int                             issued;
  int                             accepted;
  bit                             host_pending;
  bit                             draining;
  bit                             run_ok;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // even mix of BD, register and channel words
  function automatic pc_word_t make_host_word();
    logic [31:0] r;
    logic [31:0] sel;
    array_id_t   id;
    r   = next_random();
    sel = next_random();
    case (sel % 3)
      0: begin
        return {1'b0, r[25:0]};
      end
      1: begin
        // ids 0..47, so 33..47 hit no register
        id = 6'(sel[15:8] % 48);
        return {1'b1, id, r[19:0]};
      end
      default: begin
        id = {2'b11, sel[11:8]};
        return {1'b1, id, r[19:0]};
      end
    endcase
  endfunction

  // decode as the host word layout defines it
  task automatic model_accept(input pc_word_t w);
    array_id_t  id;
    conf_data_t data;
    int         ch;
    id   = w[`PC_WORD_W-2 -: `ARRAY_ID_W];
    data = w[`CONF_W-1:0];
    if (!w[`PC_WORD_W-1]) begin
      bd_exp.push_back(w[`LEAF_W+`BD_DATA_W-1:0]);
    end else if (id[`ARRAY_ID_W-1 -: 2] == 2'b11) begin
      // channel index is the low id bit
      ch = int'(id[0]);
      if (ch < `NUM_CHANS) begin
        gather[ch][gather_cnt[ch]*`CONF_W +: `CONF_W] = data;
        gather_cnt[ch]++;
        if (gather_cnt[ch] == `CHAN_CHUNKS) begin
          chan_exp[ch].push_back(gather[ch]);
          gather_cnt[ch] = 0;
        end
      end
    end else if (int'(id) < `NUM_REGS) begin
      model_regs[id] = data;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // checks

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Error: %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic check_chan_word(input int ch);
    conf_wide_t exp;
    checks++;
    assert (chan_exp[ch].size() != 0) else begin
      errors++;
      $display("channel %0d delivered a word that was never sent", ch);
    end
    if (chan_exp[ch].size() != 0) begin
      exp = chan_exp[ch].pop_front();
      check_value($sformatf("chan%0d word", ch), exp, chan_d[ch]);
    end
  endtask

  task automatic check_bd_word();
    logic [`LEAF_W+`BD_DATA_W-1:0] exp;
    checks++;
    assert (bd_exp.size() != 0) else begin
      errors++;
      $display("BD output delivered a word that was never sent");
    end
    if (bd_exp.size() != 0) begin
      exp = bd_exp.pop_front();
      check_value("bd word", 32'(exp), 32'({bd_leaf, bd_payload}));
    end
  endtask

  function automatic int expected_outputs();
    int n;
    n = bd_exp.size();
    for (int i = 0; i < `NUM_CHANS; i++) begin
      n += chan_exp[i].size();
    end
    return n;
  endfunction

  task automatic check_reset_state();
    for (int i = 0; i < `NUM_REGS; i++) begin
      check_value($sformatf("reset conf_regs[%0d]", i), 32'(`CONF_REG_RESET),
                  32'(conf_regs[i]));
    end
    check_value("reset pc_in_a", 1, 32'(pc_in_a));
    check_value("reset chan_v", 0, 32'(chan_v));
    check_value("reset bd_v", 0, 32'(bd_v));
  endtask

  //////////////////////////////////////////////////////////////////////
  // per-cycle driver and monitor

  // drive on the falling edge, then sample the handshakes for the next rise
  task automatic cycle_step();
    logic [31:0] r;
    @(negedge clk);
    r = next_random();
    if (draining) begin
      stall  = 1'b0;
      chan_a = '1;
      bd_a   = 1'b1;
    end else begin
      stall = (r[1:0] == 2'b00);
      bd_a  = (r[5:4] != 2'b00);
      for (int i = 0; i < `NUM_CHANS; i++) begin
        chan_a[i] = (r[8+2*i +: 2] != 2'b00);
      end
    end
    // an offered word stays put until it is taken
    if (!host_pending) begin
      if (!draining && issued < NUM_WORDS && r[3:2] != 2'b00) begin
        pc_in_d      = make_host_word();
        pc_in_v      = 1'b1;
        host_pending = 1'b1;
        issued++;
      end else begin
        pc_in_v = 1'b0;
      end
    end
    #1;
    if (pc_in_v && pc_in_a) begin
      model_accept(pc_in_d);
      accepted++;
      host_pending = 1'b0;
    end
    for (int i = 0; i < `NUM_CHANS; i++) begin
      if (chan_v[i] && chan_a[i]) begin
        check_chan_word(i);
      end
    end
    if (bd_v && bd_a) begin
      check_bd_word();
    end
  endtask

  task automatic run_traffic(output bit ok);
    int cycles;
    cycles = 0;
    ok     = 1'b1;
    while (accepted < NUM_WORDS && ok) begin
      cycle_step();
      cycles++;
      if (cycles > TRAFFIC_LIMIT) begin
        $display("timeout: only %0d of %0d host words were accepted", accepted, NUM_WORDS);
        ok = 1'b0;
      end
    end
  endtask

  // free all outputs and wait until they stay idle
  task automatic drain_outputs(output bit ok);
    int cycles;
    int quiet;
    cycles   = 0;
    quiet    = 0;
    ok       = 1'b1;
    draining = 1'b1;
    while (quiet < QUIET_CYCLES && ok) begin
      cycle_step();
      cycles++;
      if (chan_v == '0 && !bd_v) begin
        quiet++;
      end else begin
        quiet = 0;
      end
      if (cycles > DRAIN_LIMIT) begin
        $display("timeout: outputs did not go idle, %0d words still expected",
                 expected_outputs());
        ok = 1'b0;
      end
    end
  endtask

  task automatic final_checks();
    for (int i = 0; i < `NUM_REGS; i++) begin
      check_value($sformatf("final conf_regs[%0d]", i), 32'(model_regs[i]),
                  32'(conf_regs[i]));
    end
    checks++;
    assert (expected_outputs() == 0) else begin
      errors++;
      $display("%0d expected output words never appeared", expected_outputs());
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    stall        = 1'b0;
    pc_in_v      = 1'b0;
    pc_in_d      = '0;
    chan_a       = '0;
    bd_a         = 1'b0;
    rng          = 32'hdb04d01c;
    errors       = 0;
    checks       = 0;
    issued       = 0;
    accepted     = 0;
    host_pending = 1'b0;
    draining     = 1'b0;
    run_ok       = 1'b0;
    for (int i = 0; i < `NUM_REGS; i++) begin
      model_regs[i] = `CONF_REG_RESET;
    end
    for (int i = 0; i < `NUM_CHANS; i++) begin
      gather[i]     = '0;
      gather_cnt[i] = 0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    #1;
    check_reset_state();
    run_traffic(run_ok);
    if (run_ok) begin
      drain_outputs(run_ok);
    end
    if (run_ok) begin
      final_checks();
    end
    $display("checks: %0d, errors: %0d, host words accepted: %0d", checks, errors, accepted);
    if (run_ok && errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- common/pc_cfg.svh
`ifndef PC_CFG_SVH
`define PC_CFG_SVH

//////////////////////////////////////////////////////////////////////
// host word layout

// one host word from the PC
`define PC_WORD_W 27

// register data and channel chunk data
`define CONF_W 16

// id field of an FPGA-bound word
`define ARRAY_ID_W 6

// BD-bound word fields
`define LEAF_W 6
`define BD_DATA_W 20

//////////////////////////////////////////////////////////////////////
// counts and depths

`define NUM_REGS 33
`define NUM_CHANS 2

// transmissions joined into one channel word
`define CHAN_CHUNKS 2

`define BD_QUEUE_DEPTH 4

// value of every config register after reset
`define CONF_REG_RESET 16'h0000

`endif

//--- common/pc_pkg.sv
`default_nettype none

`include "pc_cfg.svh"

package pc_pkg;

  // raw word as sent by the host
  typedef logic [`PC_WORD_W-1:0] pc_word_t;

  // one register value or one channel chunk
  typedef logic [`CONF_W-1:0] conf_data_t;

  // a full channel word, all chunks joined
  typedef logic [`CHAN_CHUNKS*`CONF_W-1:0] conf_wide_t;

  // register or channel id
  typedef logic [`ARRAY_ID_W-1:0] array_id_t;

  typedef logic [`LEAF_W-1:0] leaf_code_t;
  typedef logic [`BD_DATA_W-1:0] bd_payload_t;

  // decoded word class
  typedef enum logic [1:0] {bd_word, reg_word, chan_word} word_kind_e;

endpackage

`default_nettype wire

//--- parser/pc_word_parser.sv
`default_nettype none

`include "pc_cfg.svh"

module pc_word_parser (
  input  wire logic                              clk,
  input  wire logic                              reset,
  input  wire logic                              word_v,
  input  wire pc_pkg::pc_word_t                  word_d,
  output logic                                   word_a,
  output pc_pkg::conf_data_t [`NUM_REGS-1:0]     conf_regs,
  output logic [`NUM_CHANS-1:0]                  chunk_v,
  output pc_pkg::conf_data_t                     chunk_d,
  input  wire logic [`NUM_CHANS-1:0]             chunk_a,
  output logic                                   bdq_v,
  output pc_pkg::leaf_code_t                     bdq_leaf,
  output pc_pkg::bd_payload_t                    bdq_payload,
  input  wire logic                              bdq_a
);

  import pc_pkg::*;

  localparam int MSB = `PC_WORD_W - 1;
  // channel select taken from the low id bits
  localparam int CHAN_SEL_W = (`NUM_CHANS > 1) ? $clog2(`NUM_CHANS) : 1;

  //////////////////////////////////////////////////////////////////////
  // field split
  //
  // BD word      [ 0 | leaf(6) | payload(20) ]
  // FPGA word    [ 1 | id(6)   | x(4) | data(16) ]
  //
  // ids with both top bits set feed a channel, the rest hit registers

  logic                  is_conf;
  array_id_t             array_id;
  conf_data_t            conf_data;
  leaf_code_t            leaf_code;
  bd_payload_t           bd_payload;
  word_kind_e            word_kind;
  logic [CHAN_SEL_W-1:0] chan_sel;
  logic                  chan_ok;
  logic                  reg_we;

  assign is_conf    = word_d[MSB];
  assign array_id   = word_d[MSB-1 -: `ARRAY_ID_W];
  assign conf_data  = word_d[`CONF_W-1:0];
  assign leaf_code  = word_d[MSB-1 -: `LEAF_W];
  assign bd_payload = word_d[`BD_DATA_W-1:0];

  always_comb begin
    if (!is_conf) begin
      word_kind = bd_word;
    end else if (&array_id[`ARRAY_ID_W-1 -: 2]) begin
      word_kind = chan_word;
    end else begin
      word_kind = reg_word;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // register bank

  // ids past the last register are swallowed
  assign reg_we = word_v && (word_kind == reg_word) && (int'(array_id) < `NUM_REGS);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        conf_regs[i] <= `CONF_REG_RESET;
      end
    end else begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        if (reg_we && int'(array_id) == i) begin
          conf_regs[i] <= conf_data;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // channel routing

  assign chan_sel = array_id[CHAN_SEL_W-1:0];
  // an index with no deserializer behind it is dropped
  assign chan_ok  = int'(chan_sel) < `NUM_CHANS;

  always_comb begin
    for (int i = 0; i < `NUM_CHANS; i++) begin
      chunk_v[i] = word_v && (word_kind == chan_word) && chan_ok && (int'(chan_sel) == i);
    end
  end

  // shared data lines, only the strobed channel takes them
  assign chunk_d = conf_data;

  //////////////////////////////////////////////////////////////////////
  // BD passthrough

  assign bdq_v       = word_v && (word_kind == bd_word);
  assign bdq_leaf    = leaf_code;
  assign bdq_payload = bd_payload;

  //////////////////////////////////////////////////////////////////////
  // input handshake

  // ack follows whichever consumer the word is routed to
  always_comb begin
    word_a = 1'b0;
    if (word_v) begin
      case (word_kind)
        bd_word:   word_a = bdq_a;
        reg_word:  word_a = 1'b1;
        chan_word: word_a = chan_ok ? chunk_a[chan_sel] : 1'b1;
        default:   word_a = 1'b0;
      endcase
    end
  end

  // only one consumer is ever strobed
  a_one_target : assert property (
    @(posedge clk) disable iff (reset)
    $onehot0({chunk_v, bdq_v})
  ) else $error("pc_word_parser: more than one consumer strobed");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator, judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_pc_config \
  -f src.f -o tb_pc_config || { echo "build failed"; exit 1; }

./obj_dir/tb_pc_config > sim.log 2>&1
cat sim.log

grep -q "Simulation PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

//--- source/bd_word_queue.sv
`default_nettype none

`include "pc_cfg.svh"

module bd_word_queue (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire logic                in_v,
  input  wire pc_pkg::leaf_code_t  in_leaf,
  input  wire pc_pkg::bd_payload_t in_payload,
  output logic                     in_a,
  output logic                     out_v,
  output pc_pkg::leaf_code_t       out_leaf,
  output pc_pkg::bd_payload_t      out_payload,
  input  wire logic                out_a
);

  import pc_pkg::*;

  localparam int DEPTH = `BD_QUEUE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  //////////////////////////////////////////////////////////////////////
  // storage and pointers

  leaf_code_t  leaf_mem    [DEPTH];
  bd_payload_t payload_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign in_a  = int'(count) != DEPTH;
  assign out_v = count != '0;
  assign push  = in_v & in_a;
  assign pop   = out_v & out_a;

  // head entry shows straight on the outputs
  assign out_leaf    = leaf_mem[rd_ptr];
  assign out_payload = payload_mem[rd_ptr];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        // wrap by hand so odd depths work too
        wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      leaf_mem[wr_ptr]    <= in_leaf;
      payload_mem[wr_ptr] <= in_payload;
    end
  end

  // occupancy stays in range and agrees with the pointer distance
  a_no_xflow : assert property (
    @(posedge clk) disable iff (reset)
    (int'(count) <= DEPTH) &&
    ((int'(wr_ptr) - int'(rd_ptr) + DEPTH) % DEPTH == int'(count) % DEPTH)
  ) else $error("bd_word_queue: occupancy overflow or underflow");

endmodule

`default_nettype wire

//--- source/conf_chan_deser.sv
`default_nettype none

`include "pc_cfg.svh"

module conf_chan_deser (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire logic               chunk_v,
  input  wire pc_pkg::conf_data_t chunk_d,
  output logic                    chunk_a,
  output logic                    chan_v,
  output pc_pkg::conf_wide_t      chan_d,
  input  wire logic               chan_a
);

  import pc_pkg::*;

  localparam int CNT_W = (`CHAN_CHUNKS > 1) ? $clog2(`CHAN_CHUNKS) : 1;

  //////////////////////////////////////////////////////////////////////
  // chunk gathering

  logic [CNT_W-1:0] cnt;
  logic             full;
  conf_wide_t       data_q;
  logic             chunk_take;
  logic             last_chunk;

  // no new chunks while the joined word waits
  assign chunk_a    = ~full;
  assign chunk_take = chunk_v & chunk_a;
  assign last_chunk = int'(cnt) == `CHAN_CHUNKS - 1;

  assign chan_v = full;
  assign chan_d = data_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cnt  <= '0;
      full <= 1'b0;
    end else begin
      if (chunk_take) begin
        if (last_chunk) begin
          cnt  <= '0;
          full <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end else if (chan_v && chan_a) begin
        full <= 1'b0;
      end
    end
  end

  // first chunk lands low, later chunks stack upward
  always_ff @(posedge clk) begin
    if (chunk_take) begin
      data_q[cnt*`CONF_W +: `CONF_W] <= chunk_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks

  // a waiting word stays up and unchanged until taken
  a_chan_hold : assert property (
    @(posedge clk) disable iff (reset)
    chan_v && !chan_a |=> chan_v && $stable(chan_d)
  ) else $error("conf_chan_deser: channel word dropped or changed before ack");

endmodule

`default_nettype wire

//--- source/pc_config_top.sv
`default_nettype none

`include "pc_cfg.svh"

module pc_config_top (
  input  wire logic                          clk,
  input  wire logic                          reset,
  input  wire logic                          stall,
  input  wire logic                          pc_in_v,
  input  wire pc_pkg::pc_word_t              pc_in_d,
  output logic                               pc_in_a,
  output pc_pkg::conf_data_t [`NUM_REGS-1:0] conf_regs,
  output logic [`NUM_CHANS-1:0]              chan_v,
  output pc_pkg::conf_wide_t [`NUM_CHANS-1:0] chan_d,
  input  wire logic [`NUM_CHANS-1:0]         chan_a,
  output logic                               bd_v,
  output pc_pkg::leaf_code_t                 bd_leaf,
  output pc_pkg::bd_payload_t                bd_payload,
  input  wire logic                          bd_a
);

  import pc_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // input side

  logic                  word_v;
  pc_word_t              word_d;
  logic                  word_a;

  pc_input_stage u_pc_input_stage (
    .clk     (clk),
    .reset   (reset),
    .stall   (stall),
    .pc_in_v (pc_in_v),
    .pc_in_d (pc_in_d),
    .pc_in_a (pc_in_a),
    .word_v  (word_v),
    .word_d  (word_d),
    .word_a  (word_a)
  );

  //////////////////////////////////////////////////////////////////////
  // parser and register bank

  logic [`NUM_CHANS-1:0] chunk_v;
  conf_data_t            chunk_d;
  logic [`NUM_CHANS-1:0] chunk_a;
  logic                  bdq_v;
  leaf_code_t            bdq_leaf;
  bd_payload_t           bdq_payload;
  logic                  bdq_a;

  pc_word_parser u_pc_word_parser (
    .clk         (clk),
    .reset       (reset),
    .word_v      (word_v),
    .word_d      (word_d),
    .word_a      (word_a),
    .conf_regs   (conf_regs),
    .chunk_v     (chunk_v),
    .chunk_d     (chunk_d),
    .chunk_a     (chunk_a),
    .bdq_v       (bdq_v),
    .bdq_leaf    (bdq_leaf),
    .bdq_payload (bdq_payload),
    .bdq_a       (bdq_a)
  );

  //////////////////////////////////////////////////////////////////////
  // output side

  // one deserializer per channel, all share chunk_d
  for (genvar i = 0; i < `NUM_CHANS; i++) begin : g_chan
    conf_chan_deser u_conf_chan_deser (
      .clk     (clk),
      .reset   (reset),
      .chunk_v (chunk_v[i]),
      .chunk_d (chunk_d),
      .chunk_a (chunk_a[i]),
      .chan_v  (chan_v[i]),
      .chan_d  (chan_d[i]),
      .chan_a  (chan_a[i])
    );
  end

  bd_word_queue u_bd_word_queue (
    .clk         (clk),
    .reset       (reset),
    .in_v        (bdq_v),
    .in_leaf     (bdq_leaf),
    .in_payload  (bdq_payload),
    .in_a        (bdq_a),
    .out_v       (bd_v),
    .out_leaf    (bd_leaf),
    .out_payload (bd_payload),
    .out_a       (bd_a)
  );

endmodule

`default_nettype wire

//--- source/pc_input_stage.sv
`default_nettype none

module pc_input_stage (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire logic             stall,
  input  wire logic             pc_in_v,
  input  wire pc_pkg::pc_word_t pc_in_d,
  output logic                  pc_in_a,
  output logic                  word_v,
  output pc_pkg::pc_word_t      word_d,
  input  wire logic             word_a
);

  import pc_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // one-entry holding register

  logic     full;
  pc_word_t data_q;
  logic     take;

  // held word is hidden while stalled
  assign word_v = full & ~stall;
  assign word_d = data_q;

  // consumer takes the word this cycle
  assign take = word_v & word_a;

  // room when empty, or when the held word leaves now
  assign pc_in_a = ~full | take;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      full <= 1'b0;
    end else if (pc_in_v && pc_in_a) begin
      full <= 1'b1;
    end else if (take) begin
      full <= 1'b0;
    end
  end

  // data only moves when a new word comes in
  always_ff @(posedge clk) begin
    if (pc_in_v && pc_in_a) begin
      data_q <= pc_in_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks

  // offered word must not change until it is acked
  a_word_stable : assert property (
    @(posedge clk) disable iff (reset)
    word_v && !word_a |=> $stable(word_d)
  ) else $error("pc_input_stage: word_d changed while waiting for ack");

endmodule

`default_nettype wire

//--- src.f
+incdir+common
common/pc_pkg.sv
source/pc_input_stage.sv
parser/pc_word_parser.sv
source/conf_chan_deser.sv
source/bd_word_queue.sv
source/pc_config_top.sv
bench/tb_pc_config.sv
